// ==== run_sim.sh ====
#!/bin/sh
# build and run the xdma adapter testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_xdma_axi_adapter_top \
  -f xdma_axi_adapter_top.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Testbench passed" \
  && echo "simulation ok" \
  || { echo "simulation not ok"; exit 1; }

// ==== src/xdma_axi_adapter_top.sv ====
//----------------------------------------
// xdma adapter top
// sender packs config and data messages
// into one write stream, receiver steers
// incoming writes to data or config
//----------------------------------------
`timescale 1ns/1ps

module xdma_axi_adapter_top #(
  parameter xdma_pkg::addr_t ClusterBaseAddr     = 48'h1000_0000,
  parameter xdma_pkg::addr_t ClusterAddressSpace = 48'h0010_0000,
  parameter xdma_pkg::addr_t MainMemBaseAddr     = 48'h8000_0000,
  parameter xdma_pkg::addr_t MainMemEndAddr      = 48'h1_0000_0000,
  parameter int              MmioSizeKb          = 16
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  xdma_pkg::addr_t               cluster_base_addr_i,
  // sender, config
  input  xdma_pkg::data_t               cfg_i,
  input  logic                          cfg_valid_i,
  output logic                          cfg_ready_o,
  // sender, data
  input  xdma_pkg::data_t               data_i,
  input  logic                          data_valid_i,
  output logic                          data_ready_o,
  input  xdma_pkg::xdma_accompany_cfg_t data_acc_cfg_i,
  // outgoing writes
  output xdma_pkg::xdma_wr_beat_t       out_wr_o,
  output logic                          out_wr_valid_o,
  input  logic                          out_wr_ready_i,
  // incoming writes
  input  xdma_pkg::xdma_wr_beat_t       in_wr_i,
  input  logic                          in_wr_valid_i,
  output logic                          in_wr_ready_o,
  // receiver outputs
  output xdma_pkg::data_t               rx_data_o,
  output logic                          rx_data_valid_o,
  input  logic                          rx_data_ready_i,
  output xdma_pkg::data_t               rx_cfg_o,
  output logic                          rx_cfg_valid_o,
  input  logic                          rx_cfg_ready_i
);

  xdma_pkg::xdma_req_desc_t cfg_desc;
  xdma_pkg::xdma_req_desc_t data_desc;

  //----------------------------------------
  // sender side
  //----------------------------------------
  xdma_desc_builder #(
    .ClusterBaseAddr    (ClusterBaseAddr),
    .ClusterAddressSpace(ClusterAddressSpace),
    .MainMemBaseAddr    (MainMemBaseAddr),
    .MainMemEndAddr     (MainMemEndAddr),
    .MmioSizeKb         (MmioSizeKb)
  ) i_desc_builder (
    .cfg_i         (cfg_i),
    .cfg_valid_i   (cfg_valid_i),
    .data_acc_cfg_i(data_acc_cfg_i),
    .cfg_desc_o    (cfg_desc),
    .data_desc_o   (data_desc)
  );

  xdma_msg_arbiter i_msg_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_i         (cfg_i),
    .cfg_valid_i   (cfg_valid_i),
    .cfg_ready_o   (cfg_ready_o),
    .data_i        (data_i),
    .data_valid_i  (data_valid_i),
    .data_ready_o  (data_ready_o),
    .cfg_desc_i    (cfg_desc),
    .data_desc_i   (data_desc),
    .out_wr_o      (out_wr_o),
    .out_wr_valid_o(out_wr_valid_o),
    .out_wr_ready_i(out_wr_ready_i)
  );

  //----------------------------------------
  // receiver side
  //----------------------------------------
  xdma_rx_demux #(
    .ClusterBaseAddr    (ClusterBaseAddr),
    .ClusterAddressSpace(ClusterAddressSpace),
    .MainMemBaseAddr    (MainMemBaseAddr),
    .MainMemEndAddr     (MainMemEndAddr),
    .MmioSizeKb         (MmioSizeKb)
  ) i_rx_demux (
    .cluster_base_addr_i(cluster_base_addr_i),
    .in_wr_i            (in_wr_i),
    .in_wr_valid_i      (in_wr_valid_i),
    .in_wr_ready_o      (in_wr_ready_o),
    .rx_data_o          (rx_data_o),
    .rx_data_valid_o    (rx_data_valid_o),
    .rx_data_ready_i    (rx_data_ready_i),
    .rx_cfg_o           (rx_cfg_o),
    .rx_cfg_valid_o     (rx_cfg_valid_o),
    .rx_cfg_ready_i     (rx_cfg_ready_i)
  );

endmodule

// ==== src/xdma_desc_builder.sv ====
//----------------------------------------
// xdma descriptor builder
// maps a config header and the data
// accompany config onto request
// descriptors aimed at remote windows
//----------------------------------------
`timescale 1ns/1ps

module xdma_desc_builder #(
  parameter xdma_pkg::addr_t ClusterBaseAddr     = 48'h1000_0000,
  parameter xdma_pkg::addr_t ClusterAddressSpace = 48'h0010_0000,
  parameter xdma_pkg::addr_t MainMemBaseAddr     = 48'h8000_0000,
  parameter xdma_pkg::addr_t MainMemEndAddr      = 48'h1_0000_0000,
  parameter int              MmioSizeKb          = 16
) (
  // config stream, first frame is the header
  input  xdma_pkg::data_t               cfg_i,
  input  logic                          cfg_valid_i,
  // data burst side config
  input  xdma_pkg::xdma_accompany_cfg_t data_acc_cfg_i,
  // descriptors to the arbiter
  output xdma_pkg::xdma_req_desc_t      cfg_desc_o,
  output xdma_pkg::xdma_req_desc_t      data_desc_o
);

  // one window per channel, quarter of the mmio space
  localparam xdma_pkg::addr_t WinSize = xdma_pkg::addr_t'((MmioSizeKb / 4) * 1024);

  xdma_pkg::xdma_cfg_frame_t cfg_hdr;
  // address of the remote side of the transfer
  xdma_pkg::addr_t           cfg_remote_side;
  xdma_pkg::addr_t           cfg_region_end;
  xdma_pkg::addr_t           data_region_end;

  //----------------------------------------
  // config message
  //----------------------------------------
  assign cfg_hdr = xdma_pkg::xdma_cfg_frame_t'(cfg_i);

  // read: remote is the reader
  // write: remote is the writer
  assign cfg_remote_side = cfg_hdr.dma_type ? cfg_hdr.writer_addr : cfg_hdr.reader_addr;

  assign cfg_region_end = xdma_pkg::region_end(cfg_remote_side, ClusterBaseAddr,
                                               ClusterAddressSpace, MainMemBaseAddr,
                                               MainMemEndAddr);

  always_comb begin
    cfg_desc_o.dma_id      = cfg_hdr.dma_id;
    cfg_desc_o.dma_type    = cfg_hdr.dma_type;
    cfg_desc_o.remote_addr = xdma_pkg::window_base(cfg_region_end, xdma_pkg::ChanCfg,
                                                   WinSize);
    // frame count, header included
    cfg_desc_o.dma_length  = xdma_pkg::len_t'(cfg_hdr.frame_length);
    // only meaningful on a header, the arbiter never samples body frames
    cfg_desc_o.ready_to_transfer = cfg_valid_i;
  end

  //----------------------------------------
  // data burst
  //----------------------------------------
  // destination decides the window for both read and write bursts
  assign data_region_end = xdma_pkg::region_end(data_acc_cfg_i.dst_addr, ClusterBaseAddr,
                                                ClusterAddressSpace, MainMemBaseAddr,
                                                MainMemEndAddr);

  always_comb begin
    data_desc_o.dma_id      = data_acc_cfg_i.dma_id;
    data_desc_o.dma_type    = data_acc_cfg_i.dma_type;
    data_desc_o.remote_addr = xdma_pkg::window_base(data_region_end, xdma_pkg::ChanData,
                                                    WinSize);
    data_desc_o.dma_length  = data_acc_cfg_i.dma_length;
    data_desc_o.ready_to_transfer = data_acc_cfg_i.ready_to_transfer;
  end

endmodule

// ==== src/xdma_msg_arbiter.sv ====
//----------------------------------------
// xdma message arbiter
// locks onto one whole message, config
// before data, and streams its beats
// with first/last marking
//----------------------------------------
`timescale 1ns/1ps

module xdma_msg_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // config source
  input  xdma_pkg::data_t          cfg_i,
  input  logic                     cfg_valid_i,
  output logic                     cfg_ready_o,
  // data source
  input  xdma_pkg::data_t          data_i,
  input  logic                     data_valid_i,
  output logic                     data_ready_o,
  // descriptors of the pending first beats
  input  xdma_pkg::xdma_req_desc_t cfg_desc_i,
  input  xdma_pkg::xdma_req_desc_t data_desc_i,
  // outgoing write beats
  output xdma_pkg::xdma_wr_beat_t  out_wr_o,
  output logic                     out_wr_valid_o,
  input  logic                     out_wr_ready_i
);

  typedef enum logic {
    ArbIdle,
    ArbLocked
  } arb_state_e;

  arb_state_e               state_q, state_d;
  xdma_pkg::xdma_chan_e     chan_q, chan_d;
  xdma_pkg::xdma_req_desc_t desc_q, desc_d;
  logic                     desc_load;
  xdma_pkg::len_t           beat_cnt_q, beat_cnt_d;

  // header beat with a descriptor ready
  logic                     cfg_req;
  logic                     data_req;
  // selected source
  xdma_pkg::data_t          src_data;
  logic                     src_valid;
  logic                     locked;
  logic                     beat_xfer;
  logic                     last_beat;

  assign cfg_req  = cfg_valid_i & cfg_desc_i.ready_to_transfer;
  assign data_req = data_valid_i & data_desc_i.ready_to_transfer;
  assign locked   = (state_q == ArbLocked);

  //----------------------------------------
  // source select and beat forming
  //----------------------------------------
  always_comb begin
    src_data  = '0;
    src_valid = 1'b0;
    case (chan_q)
      xdma_pkg::ChanCfg: begin
        src_data  = cfg_i;
        src_valid = cfg_valid_i;
      end
      xdma_pkg::ChanData: begin
        src_data  = data_i;
        src_valid = data_valid_i;
      end
      // grant and finish have no source here
      default: begin
        src_data  = '0;
        src_valid = 1'b0;
      end
    endcase
  end

  // zero length counts as a single beat
  assign last_beat = (desc_q.dma_length == '0) ||
                     (beat_cnt_q == desc_q.dma_length - xdma_pkg::len_t'(1));

  assign out_wr_valid_o = locked & src_valid;
  assign beat_xfer      = out_wr_valid_o & out_wr_ready_i;

  always_comb begin
    out_wr_o.addr  = desc_q.remote_addr;
    out_wr_o.data  = src_data;
    out_wr_o.first = (beat_cnt_q == '0);
    out_wr_o.last  = last_beat;
  end

  // sink ready straight through to the locked source
  assign cfg_ready_o  = locked & (chan_q == xdma_pkg::ChanCfg) & out_wr_ready_i;
  assign data_ready_o = locked & (chan_q == xdma_pkg::ChanData) & out_wr_ready_i;

  //----------------------------------------
  // lock FSM
  //----------------------------------------
  always_comb begin
    state_d    = state_q;
    chan_d     = chan_q;
    beat_cnt_d = beat_cnt_q;
    desc_d     = cfg_desc_i;
    desc_load  = 1'b0;
    case (state_q)
      ArbIdle: begin
        beat_cnt_d = '0;
        // config wins over data
        if (cfg_req) begin
          state_d   = ArbLocked;
          chan_d    = xdma_pkg::ChanCfg;
          desc_d    = cfg_desc_i;
          desc_load = 1'b1;
        end else if (data_req) begin
          state_d   = ArbLocked;
          chan_d    = xdma_pkg::ChanData;
          desc_d    = data_desc_i;
          desc_load = 1'b1;
        end
      end
      ArbLocked: begin
        if (beat_xfer) begin
          if (last_beat) begin
            // body frames never reach the header decode
            state_d    = ArbIdle;
            beat_cnt_d = '0;
          end else begin
            beat_cnt_d = beat_cnt_q + xdma_pkg::len_t'(1);
          end
        end
      end
      default: state_d = ArbIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ArbIdle;
      chan_q     <= xdma_pkg::ChanData;
      beat_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      chan_q     <= chan_d;
      beat_cnt_q <= beat_cnt_d;
    end
  end

  // descriptor of the locked message
  always_ff @(posedge clk_i) begin
    if (desc_load) begin
      desc_q <= desc_d;
    end
  end

endmodule

// ==== src/xdma_pkg.sv ====
//----------------------------------------
// xdma shared definitions
// field widths, frame and beat layouts,
// message channels and the window map
//----------------------------------------
package xdma_pkg;

  //----------------------------------------
  // widths
  //----------------------------------------
  localparam int AddrWidth     = 48;
  localparam int DataWidth     = 128;
  localparam int IdWidth       = 8;
  localparam int FrameLenWidth = 8;
  localparam int LenWidth      = 16;

  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [IdWidth-1:0]       id_t;
  typedef logic [FrameLenWidth-1:0] frame_len_t;
  typedef logic [LenWidth-1:0]      len_t;

  // message channels, window k sits (k+1) windows below region end
  typedef enum logic [1:0] {
    ChanData   = 2'd0,
    ChanCfg    = 2'd1,
    ChanGrant  = 2'd2,
    ChanFinish = 2'd3
  } xdma_chan_e;

  //----------------------------------------
  // message layouts
  //----------------------------------------
  // header frame, fills one full data word
  typedef struct packed {
    logic [14:0] spare;
    addr_t       writer_addr;
    addr_t       reader_addr;
    id_t         dma_id;
    frame_len_t  frame_length;
    // 0 read, 1 write
    logic        dma_type;
  } xdma_cfg_frame_t;

  // held stable by the source for a whole data burst
  typedef struct packed {
    id_t   dma_id;
    logic  dma_type;
    addr_t src_addr;
    addr_t dst_addr;
    len_t  dma_length;
    logic  ready_to_transfer;
  } xdma_accompany_cfg_t;

  typedef struct packed {
    id_t   dma_id;
    logic  dma_type;
    addr_t remote_addr;
    len_t  dma_length;
    logic  ready_to_transfer;
  } xdma_req_desc_t;

  // one write beat on the link
  typedef struct packed {
    addr_t addr;
    data_t data;
    logic  first;
    logic  last;
  } xdma_wr_beat_t;

  //----------------------------------------
  // window map
  //----------------------------------------
  // end of the cluster or main memory holding addr
  function automatic addr_t region_end(input addr_t addr, input addr_t cluster_base,
                                       input addr_t cluster_space, input addr_t main_base,
                                       input addr_t main_end);
    addr_t cluster_idx;
    cluster_idx = (addr - cluster_base) / cluster_space;
    if (addr >= main_base) begin
      return main_end;
    end
    return cluster_base + (cluster_idx + addr_t'(1)) * cluster_space;
  endfunction

  function automatic addr_t window_base(input addr_t end_addr, input xdma_chan_e chan,
                                        input addr_t win_size);
    return end_addr - (addr_t'(chan) + addr_t'(1)) * win_size;
  endfunction

endpackage

// ==== src/xdma_rx_demux.sv ====
//----------------------------------------
// xdma receive demux
// decodes incoming write beats against
// the local windows, steers data and
// config, drops everything else
//----------------------------------------
`timescale 1ns/1ps

module xdma_rx_demux #(
  parameter xdma_pkg::addr_t ClusterBaseAddr     = 48'h1000_0000,
  parameter xdma_pkg::addr_t ClusterAddressSpace = 48'h0010_0000,
  parameter xdma_pkg::addr_t MainMemBaseAddr     = 48'h8000_0000,
  parameter xdma_pkg::addr_t MainMemEndAddr      = 48'h1_0000_0000,
  parameter int              MmioSizeKb          = 16
) (
  // base of the local cluster, or main memory base
  input  xdma_pkg::addr_t         cluster_base_addr_i,
  // incoming writes
  input  xdma_pkg::xdma_wr_beat_t in_wr_i,
  input  logic                    in_wr_valid_i,
  output logic                    in_wr_ready_o,
  // received data
  output xdma_pkg::data_t         rx_data_o,
  output logic                    rx_data_valid_o,
  input  logic                    rx_data_ready_i,
  // received config
  output xdma_pkg::data_t         rx_cfg_o,
  output logic                    rx_cfg_valid_o,
  input  logic                    rx_cfg_ready_i
);

  localparam xdma_pkg::addr_t WinSize = xdma_pkg::addr_t'((MmioSizeKb / 4) * 1024);

  xdma_pkg::addr_t local_end;
  xdma_pkg::addr_t data_win_lo;
  xdma_pkg::addr_t cfg_win_lo;
  logic            data_hit;
  logic            cfg_hit;

  //----------------------------------------
  // local window map
  //----------------------------------------
  // main memory owns the top of the space, a cluster its own slot
  assign local_end = (cluster_base_addr_i == MainMemBaseAddr) ? MainMemEndAddr :
                     xdma_pkg::region_end(cluster_base_addr_i, ClusterBaseAddr,
                                          ClusterAddressSpace, MainMemBaseAddr,
                                          MainMemEndAddr);

  assign data_win_lo = xdma_pkg::window_base(local_end, xdma_pkg::ChanData, WinSize);
  assign cfg_win_lo  = xdma_pkg::window_base(local_end, xdma_pkg::ChanCfg, WinSize);

  // half open ranges, one window wide
  assign data_hit = (in_wr_i.addr >= data_win_lo) &&
                    (in_wr_i.addr < data_win_lo + WinSize);
  assign cfg_hit  = (in_wr_i.addr >= cfg_win_lo) &&
                    (in_wr_i.addr < cfg_win_lo + WinSize);

  //----------------------------------------
  // steering
  //----------------------------------------
  // payload goes to both, valid selects
  assign rx_data_o = in_wr_i.data;
  assign rx_cfg_o  = in_wr_i.data;

  assign rx_data_valid_o = in_wr_valid_i & data_hit;
  assign rx_cfg_valid_o  = in_wr_valid_i & cfg_hit;

  // grant, finish and unmapped beats are sunk at once
  always_comb begin
    if (data_hit) begin
      in_wr_ready_o = rx_data_ready_i;
    end else if (cfg_hit) begin
      in_wr_ready_o = rx_cfg_ready_i;
    end else begin
      in_wr_ready_o = 1'b1;
    end
  end

endmodule

// ==== testbench/tb_xdma_axi_adapter_top.sv ====
//----------------------------------------
// xdma adapter testbench
// replays the stimulus file into both
// sender sources and the incoming link,
// checks outgoing beats and receives
//----------------------------------------
`timescale 1ns/1ps

module tb_xdma_axi_adapter_top;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  xdma_pkg::addr_t               cluster_base_addr_i;
  xdma_pkg::data_t               cfg_i;
  logic                          cfg_valid_i;
  logic                          cfg_ready_o;
  xdma_pkg::data_t               data_i;
  logic                          data_valid_i;
  logic                          data_ready_o;
  xdma_pkg::xdma_accompany_cfg_t data_acc_cfg_i;
  xdma_pkg::xdma_wr_beat_t       out_wr_o;
  logic                          out_wr_valid_o;
  logic                          out_wr_ready_i;
  xdma_pkg::xdma_wr_beat_t       in_wr_i;
  logic                          in_wr_valid_i;
  logic                          in_wr_ready_o;
  xdma_pkg::data_t               rx_data_o;
  logic                          rx_data_valid_o;
  logic                          rx_data_ready_i;
  xdma_pkg::data_t               rx_cfg_o;
  logic                          rx_cfg_valid_o;
  logic                          rx_cfg_ready_i;

  // parsed stimulus, one entry per message or beat
  xdma_pkg::data_t               cfg_hdr_q[$];
  xdma_pkg::frame_len_t          cfg_cnt_q[$];
  xdma_pkg::data_t               cfg_base_q[$];
  xdma_pkg::xdma_accompany_cfg_t acc_q[$];
  xdma_pkg::data_t               data_base_q[$];
  xdma_pkg::addr_t               in_base_q[$];
  xdma_pkg::xdma_wr_beat_t       in_beat_q[$];
  // expected outgoing beats and receives, in order
  xdma_pkg::xdma_wr_beat_t       exp_beat_q[$];
  logic                          exp_chan_q[$];
  xdma_pkg::data_t               exp_rx_q[$];

  int          n_cmds;
  int          n_checks;
  int          n_mismatch;
  int          n_other;
  logic        loaded;
  logic        started;
  logic        cfg_done;
  logic        data_done;
  logic        in_done;
  logic [31:0] rng_state;

  xdma_axi_adapter_top #(
    .ClusterBaseAddr    (48'h1000_0000),
    .ClusterAddressSpace(48'h0010_0000),
    .MainMemBaseAddr    (48'h8000_0000),
    .MainMemEndAddr     (48'h1_0000_0000),
    .MmioSizeKb         (16)
  ) uut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .cluster_base_addr_i(cluster_base_addr_i),
    .cfg_i              (cfg_i),
    .cfg_valid_i        (cfg_valid_i),
    .cfg_ready_o        (cfg_ready_o),
    .data_i             (data_i),
    .data_valid_i       (data_valid_i),
    .data_ready_o       (data_ready_o),
    .data_acc_cfg_i     (data_acc_cfg_i),
    .out_wr_o           (out_wr_o),
    .out_wr_valid_o     (out_wr_valid_o),
    .out_wr_ready_i     (out_wr_ready_i),
    .in_wr_i            (in_wr_i),
    .in_wr_valid_i      (in_wr_valid_i),
    .in_wr_ready_o      (in_wr_ready_o),
    .rx_data_o          (rx_data_o),
    .rx_data_valid_o    (rx_data_valid_o),
    .rx_data_ready_i    (rx_data_ready_i),
    .rx_cfg_o           (rx_cfg_o),
    .rx_cfg_valid_o     (rx_cfg_valid_o),
    .rx_cfg_ready_i     (rx_cfg_ready_i)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  //----------------------------------------
  // helpers
  //----------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic void check_value(input string name, input logic [127:0] got,
                                      input logic [127:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_mismatch++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endfunction

  function automatic void check_out_beat(input xdma_pkg::xdma_wr_beat_t got);
    xdma_pkg::xdma_wr_beat_t exp;
    assert (exp_beat_q.size() > 0) else begin
      n_other++;
      $display("ERROR: outgoing beat at %0t while no beat was expected", $time);
    end
    if (exp_beat_q.size() > 0) begin
      exp = exp_beat_q.pop_front();
      check_value("out_wr_o.addr", 128'(got.addr), 128'(exp.addr));
      check_value("out_wr_o.data", got.data, exp.data);
      check_value("out_wr_o.first", 128'(got.first), 128'(exp.first));
      check_value("out_wr_o.last", 128'(got.last), 128'(exp.last));
    end
  endfunction

  function automatic void check_rx(input logic chan, input xdma_pkg::data_t got);
    logic            exp_chan;
    xdma_pkg::data_t exp_data;
    string           name;
    name = chan ? "rx_cfg_o" : "rx_data_o";
    assert (exp_rx_q.size() > 0) else begin
      n_other++;
      $display("ERROR: %s delivered a beat at %0t while none was expected", name, $time);
    end
    if (exp_rx_q.size() > 0) begin
      exp_chan = exp_chan_q.pop_front();
      exp_data = exp_rx_q.pop_front();
      check_value("rx channel", 128'(chan), 128'(exp_chan));
      check_value(name, got, exp_data);
    end
  endfunction

  function automatic void report_counts();
    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
  endfunction

  //----------------------------------------
  // stimulus file
  //----------------------------------------
  task automatic load_stimulus(input int fd);
    int                            c;
    int                            n;
    int                            want;
    logic [7:0]                    op;
    logic [127:0]                  v0, v1, v2, v3, v4, v5;
    xdma_pkg::xdma_cfg_frame_t     hdr;
    xdma_pkg::xdma_accompany_cfg_t acc;
    xdma_pkg::xdma_wr_beat_t       beat;
    c = $fgetc(fd);
    while (c >= 0) begin
      op   = c[7:0];
      n    = 0;
      want = 0;
      case (op)
        // comment, skip to newline
        "#": begin
          while (c >= 0 && c != 10) begin
            c = $fgetc(fd);
          end
        end
        "C": begin
          want = 6;
          n = $fscanf(fd, " %h %h %h %h %h %h", v0, v1, v2, v3, v4, v5);
          hdr              = '0;
          hdr.dma_type     = v0[0];
          hdr.reader_addr  = v1[47:0];
          hdr.writer_addr  = v2[47:0];
          hdr.dma_id       = v3[7:0];
          hdr.frame_length = v4[7:0];
          cfg_hdr_q.push_back(xdma_pkg::data_t'(hdr));
          cfg_cnt_q.push_back(v4[7:0]);
          cfg_base_q.push_back(v5);
        end
        "D": begin
          want = 6;
          n = $fscanf(fd, " %h %h %h %h %h %h", v0, v1, v2, v3, v4, v5);
          acc.dma_id            = v0[7:0];
          acc.dma_type          = v1[0];
          acc.src_addr          = v2[47:0];
          acc.dst_addr          = v3[47:0];
          acc.dma_length        = v4[15:0];
          acc.ready_to_transfer = 1'b1;
          acc_q.push_back(acc);
          data_base_q.push_back(v5);
        end
        "I": begin
          want = 3;
          n = $fscanf(fd, " %h %h %h", v0, v1, v2);
          beat.addr  = v1[47:0];
          beat.data  = v2;
          beat.first = 1'b0;
          beat.last  = 1'b0;
          in_base_q.push_back(v0[47:0]);
          in_beat_q.push_back(beat);
        end
        "E": begin
          want = 4;
          n = $fscanf(fd, " %h %h %h %h", v0, v1, v2, v3);
          beat.addr  = v0[47:0];
          beat.data  = v1;
          beat.first = v2[0];
          beat.last  = v3[0];
          exp_beat_q.push_back(beat);
        end
        "R": begin
          want = 2;
          n = $fscanf(fd, " %h %h", v0, v1);
          exp_chan_q.push_back(v0[0]);
          exp_rx_q.push_back(v1);
        end
        default: begin
          // whitespace between lines
          want = 0;
        end
      endcase
      if (want > 0) begin
        n_cmds++;
        assert (n == want) else begin
          n_other++;
          $display("ERROR: stimulus line %0d with opcode %s has missing fields", n_cmds, op);
        end
      end
      c = $fgetc(fd);
    end
  endtask

  //----------------------------------------
  // drivers, all on the falling edge
  //----------------------------------------
  task automatic send_cfg_frame(input xdma_pkg::data_t frame);
    @(negedge clk_i);
    cfg_i       = frame;
    cfg_valid_i = 1'b1;
    @(posedge clk_i);
    while (!cfg_ready_o) begin
      @(posedge clk_i);
    end
  endtask

  task automatic send_data_beat(input xdma_pkg::xdma_accompany_cfg_t acc,
                                input xdma_pkg::data_t d);
    @(negedge clk_i);
    data_acc_cfg_i = acc;
    data_i         = d;
    data_valid_i   = 1'b1;
    @(posedge clk_i);
    while (!data_ready_o) begin
      @(posedge clk_i);
    end
  endtask

  task automatic send_in_beat(input xdma_pkg::addr_t base, input xdma_pkg::xdma_wr_beat_t b);
    @(negedge clk_i);
    cluster_base_addr_i = base;
    in_wr_i             = b;
    in_wr_valid_i       = 1'b1;
    @(posedge clk_i);
    while (!in_wr_ready_o) begin
      @(posedge clk_i);
    end
  endtask

  // body frame j of a config message carries base + j
  initial begin : cfg_driver
    int              cnt;
    xdma_pkg::data_t base;
    wait (started === 1'b1);
    while (cfg_hdr_q.size() > 0) begin
      cnt  = int'(cfg_cnt_q.pop_front());
      base = cfg_base_q.pop_front();
      send_cfg_frame(cfg_hdr_q.pop_front());
      for (int j = 1; j < cnt; j++) begin
        send_cfg_frame(base + xdma_pkg::data_t'(j));
      end
    end
    @(negedge clk_i);
    cfg_valid_i = 1'b0;
    cfg_done    = 1'b1;
  end

  // data beat k carries base + k, side config held for the burst
  initial begin : data_driver
    xdma_pkg::xdma_accompany_cfg_t acc;
    xdma_pkg::data_t               base;
    wait (started === 1'b1);
    while (acc_q.size() > 0) begin
      acc  = acc_q.pop_front();
      base = data_base_q.pop_front();
      for (int k = 0; k < int'(acc.dma_length); k++) begin
        send_data_beat(acc, base + xdma_pkg::data_t'(k));
      end
    end
    @(negedge clk_i);
    data_valid_i = 1'b0;
    data_done    = 1'b1;
  end

  initial begin : in_driver
    wait (started === 1'b1);
    while (in_beat_q.size() > 0) begin
      send_in_beat(in_base_q.pop_front(), in_beat_q.pop_front());
    end
    @(negedge clk_i);
    in_wr_valid_i = 1'b0;
    in_done       = 1'b1;
  end

  // random back-pressure on all sinks
  always @(negedge clk_i) begin
    if (started === 1'b1) begin
      rng_state       = lcg_next(rng_state);
      out_wr_ready_i  = (rng_state[31:30] != 2'b00);
      rng_state       = lcg_next(rng_state);
      rx_data_ready_i = rng_state[31];
      rng_state       = lcg_next(rng_state);
      rx_cfg_ready_i  = rng_state[31];
    end
  end

  //----------------------------------------
  // monitors, sampled on the rising edge
  //----------------------------------------
  always @(posedge clk_i) begin
    if (rst_ni === 1'b1) begin
      if (out_wr_valid_o && out_wr_ready_i) begin
        check_out_beat(out_wr_o);
      end
      if (rx_data_valid_o && rx_data_ready_i) begin
        check_rx(1'b0, rx_data_o);
      end
      if (rx_cfg_valid_o && rx_cfg_ready_i) begin
        check_rx(1'b1, rx_cfg_o);
      end
    end
  end

  // 200 cycles per stimulus line
  initial begin : watchdog
    wait (loaded === 1'b1);
    repeat (n_cmds * 200) @(posedge clk_i);
    $display("ERROR: run did not finish within %0d cycles, beats are missing", n_cmds * 200);
    report_counts();
    $display("Testbench failed");
    $finish;
  end

  //----------------------------------------
  // main sequence
  //----------------------------------------
  initial begin : main
    int fd;
    rst_ni              = 1'b0;
    cluster_base_addr_i = '0;
    cfg_i               = '0;
    cfg_valid_i         = 1'b0;
    data_i              = '0;
    data_valid_i        = 1'b0;
    data_acc_cfg_i      = '0;
    out_wr_ready_i      = 1'b1;
    in_wr_i             = '0;
    in_wr_valid_i       = 1'b0;
    rx_data_ready_i     = 1'b0;
    rx_cfg_ready_i      = 1'b0;
    n_cmds              = 0;
    n_checks            = 0;
    n_mismatch          = 0;
    n_other             = 0;
    loaded              = 1'b0;
    started             = 1'b0;
    cfg_done            = 1'b0;
    data_done           = 1'b0;
    in_done             = 1'b0;
    rng_state           = 32'd69;
    fd = $fopen("testbench/xdma_stimulus.txt", "r");
    if (fd == 0) begin
      $display("ERROR: the stimulus file could not be opened");
      report_counts();
      $display("Testbench failed");
      $finish;
    end else begin
      load_stimulus(fd);
      $fclose(fd);
      loaded = 1'b1;
      // reset held for 4 cycles, released between edges
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      // first cycle out of reset, nothing may be valid
      @(posedge clk_i);
      check_value("out_wr_valid_o", 128'(out_wr_valid_o), '0);
      check_value("rx_data_valid_o", 128'(rx_data_valid_o), '0);
      check_value("rx_cfg_valid_o", 128'(rx_cfg_valid_o), '0);
      check_value("cfg_ready_o", 128'(cfg_ready_o), '0);
      check_value("data_ready_o", 128'(data_ready_o), '0);
      started = 1'b1;
      while (!(cfg_done && data_done && in_done && exp_beat_q.size() == 0 &&
               exp_rx_q.size() == 0)) begin
        @(posedge clk_i);
      end
      // a few idle cycles to catch stray beats
      repeat (4) @(posedge clk_i);
      report_counts();
      if (n_mismatch == 0 && n_other == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

// ==== testbench/xdma_stimulus.txt ====
# C type reader writer id frames body_base | D id type src dst len body_base
# I local_base addr data | E addr data first last | R chan(0 data, 1 cfg) data
# config messages: read to cluster 3, write to cluster 7, read to main memory
C 0 10300000 10500000 11 3 a0
C 1 10100000 10700000 22 2 b0
C 0 90000000 10000000 33 1 0
# data bursts: main memory, cluster 5, cluster 0
D 44 1 10200000 88000000 3 1000
D 55 0 90000000 10501234 2 2000
D 66 1 0 10000010 1 3000
# all config beats leave before the first data beat
E 103fe000 0000000020a000000000206000002206 1 0
E 103fe000 a1 0 0
E 103fe000 a2 0 1
E 107fe000 0000000020e000000000202000004405 1 0
E 107fe000 b1 0 1
E ffffe000 00000000200000000001200000006602 1 1
E fffff000 1000 1 0
E fffff000 1001 0 0
E fffff000 1002 0 1
E 105ff000 2000 1 0
E 105ff000 2001 0 1
E 100ff000 3000 1 1
# incoming, local cluster 2 ends at 10300000
I 10200000 102ff000 c001
I 10200000 102feff8 c002
I 10200000 102fd000 c003
I 10200000 102fc800 c004
I 10200000 102fffff c005
I 10200000 10300000 c006
I 10200000 1040f000 c007
# incoming, local main memory ends at 100000000
I 80000000 fffff000 c008
I 80000000 ffffe010 c009
I 80000000 ffffd000 c00a
I 80000000 ffffc000 c00b
I 80000000 102ff000 c00c
I 80000000 fffffff0 c00d
I 80000000 ffffeff0 c00e
# only data and config window hits come out
R 0 c001
R 1 c002
R 0 c005
R 0 c008
R 1 c009
R 0 c00d
R 1 c00e

// ==== xdma_axi_adapter_top.f ====
src/xdma_pkg.sv
src/xdma_desc_builder.sv
src/xdma_msg_arbiter.sv
src/xdma_rx_demux.sv
src/xdma_axi_adapter_top.sv
testbench/tb_xdma_axi_adapter_top.sv
